/* mips_isa_pkg.sv */
package mips_isa_pkg;

  typedef logic [31:0] word_t;      // data word, address or instruction.
  typedef logic [4:0]  reg_addr_t;  // register number.
  typedef logic [4:0]  shamt_t;     // shift amount.

  localparam word_t reset_vector = 32'hBFC0_0000;

  localparam reg_addr_t reg_v0 = 5'd2;
  localparam reg_addr_t reg_v3 = 5'd3;
  localparam reg_addr_t reg_ra = 5'd31;  // link register for jal.

  // primary opcodes, bits 31:26 of the instruction.
  typedef enum logic [5:0] {
    op_special = 6'h00,  // register-type, decoded further by funct.
    op_j       = 6'h02,
    op_jal     = 6'h03,
    op_beq     = 6'h04,
    op_bne     = 6'h05,
    op_addiu   = 6'h09,
    op_slti    = 6'h0A,
    op_andi    = 6'h0C,
    op_ori     = 6'h0D,
    op_xori    = 6'h0E,
    op_lui     = 6'h0F,
    op_lb      = 6'h20,
    op_lh      = 6'h21,
    op_lw      = 6'h23,
    op_lbu     = 6'h24,
    op_lhu     = 6'h25,
    op_sw      = 6'h2B
  } opcode_e;

  // function codes of op_special, bits 5:0 of the instruction.
  typedef enum logic [5:0] {
    fn_sll  = 6'h00,
    fn_srl  = 6'h02,
    fn_sra  = 6'h03,
    fn_jr   = 6'h08,
    fn_addu = 6'h21,
    fn_subu = 6'h23,
    fn_and  = 6'h24,
    fn_or   = 6'h25,
    fn_xor  = 6'h26,
    fn_slt  = 6'h2A,
    fn_sltu = 6'h2B
  } funct_e;

endpackage

/* mips_ctrl_pkg.sv */
package mips_ctrl_pkg;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_lui
  } alu_op_e;

  typedef enum logic [2:0] {
    ld_word,
    ld_byte_s,
    ld_byte_u,
    ld_half_s,
    ld_half_u
  } load_kind_e;

  typedef enum logic [1:0] {
    wb_alu,
    wb_mem,
    wb_link  // return address pc+8.
  } wb_src_e;

  typedef enum logic [1:0] {
    dst_rt,
    dst_rd,
    dst_ra
  } dst_sel_e;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       alu_src_imm;     // operand b is the extended immediate.
    logic       imm_zero_ext;    // zero extend instead of sign extend.
    logic       shift_by_shamt;  // shift count from the shamt field.
    logic       reg_write;
    dst_sel_e   dst_sel;
    wb_src_e    wb_src;
    logic       mem_read;
    logic       mem_write;
    load_kind_e load_kind;
    logic       branch_eq;
    logic       branch_ne;
    logic       jump_imm;        // j and jal.
    logic       jump_reg;        // jr.
  } ctrl_t;

  // the control word of an instruction that changes no state.
  localparam ctrl_t ctrl_nop = '{
    alu_op:         alu_add,
    dst_sel:        dst_rt,
    wb_src:         wb_alu,
    load_kind:      ld_word,
    default:        1'b0
  };

endpackage

/* mips_alu.sv */
`timescale 1ns/100ps

module mips_alu
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;
(
  input  alu_op_e op,
  input  word_t   a,
  input  word_t   b,
  input  shamt_t  shamt,
  output word_t   result,
  output logic    zero
);

  logic lt_signed;
  logic lt_unsigned;

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_and:  result = a & b;
      alu_or:   result = a | b;
      alu_xor:  result = a ^ b;
      alu_slt:  result = {31'b0, lt_signed};
      alu_sltu: result = {31'b0, lt_unsigned};
      alu_sll:  result = b << shamt;  // shifts always act on operand b.
      alu_srl:  result = b >> shamt;
      alu_sra:  result = word_t'($signed(b) >>> shamt);
      alu_lui:  result = {b[15:0], 16'b0};
      default:  result = a + b;
    endcase
  end

  // beq and bne subtract and look at this flag.
  assign zero = (result == '0);

endmodule

/* mips_regfile.sv */
`timescale 1ns/100ps

module mips_regfile
  import mips_isa_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      write_en,
  input  reg_addr_t rs_addr,
  input  reg_addr_t rt_addr,
  input  reg_addr_t rd_addr,
  input  word_t     rd_data,
  output word_t     rs_data,
  output word_t     rt_data,
  output word_t     v0,
  output word_t     v3
);

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;  // register 0 stays at its reset value of zero.
    end
  end

  assign rs_data = regs[rs_addr];
  assign rt_data = regs[rt_addr];

  // continuous taps for the debug ports.
  assign v0 = regs[reg_v0];
  assign v3 = regs[reg_v3];

endmodule

/* mips_controller.sv */
`timescale 1ns/100ps

module mips_controller
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;
(
  input  word_t instr,
  output ctrl_t ctrl
);

  opcode_e opcode;
  funct_e  funct;

  assign opcode = opcode_e'(instr[31:26]);
  assign funct  = funct_e'(instr[5:0]);

  always_comb begin
    ctrl = ctrl_nop;  // anything not listed below falls through as a nop.
    case (opcode)
      op_special: begin
        ctrl.dst_sel   = dst_rd;
        ctrl.reg_write = 1'b1;
        case (funct)
          fn_addu: ctrl.alu_op = alu_add;
          fn_subu: ctrl.alu_op = alu_sub;
          fn_and:  ctrl.alu_op = alu_and;
          fn_or:   ctrl.alu_op = alu_or;
          fn_xor:  ctrl.alu_op = alu_xor;
          fn_slt:  ctrl.alu_op = alu_slt;
          fn_sltu: ctrl.alu_op = alu_sltu;
          fn_sll, fn_srl, fn_sra: begin
            ctrl.shift_by_shamt = 1'b1;
            if (funct == fn_sll) begin
              ctrl.alu_op = alu_sll;
            end else if (funct == fn_srl) begin
              ctrl.alu_op = alu_srl;
            end else begin
              ctrl.alu_op = alu_sra;
            end
          end
          fn_jr: begin
            ctrl.reg_write = 1'b0;
            ctrl.jump_reg  = 1'b1;
          end
          default: ctrl.reg_write = 1'b0;
        endcase
      end
      op_j: ctrl.jump_imm = 1'b1;
      op_jal: begin
        ctrl.jump_imm  = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.dst_sel   = dst_ra;
        ctrl.wb_src    = wb_link;
      end
      op_beq, op_bne: begin
        ctrl.alu_op    = alu_sub;  // the datapath compares through the zero flag.
        ctrl.branch_eq = (opcode == op_beq);
        ctrl.branch_ne = (opcode == op_bne);
      end
      op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui: begin
        ctrl.alu_src_imm  = 1'b1;
        ctrl.reg_write    = 1'b1;
        ctrl.imm_zero_ext = (opcode == op_andi) || (opcode == op_ori) ||
                            (opcode == op_xori);
        case (opcode)
          op_slti: ctrl.alu_op = alu_slt;
          op_andi: ctrl.alu_op = alu_and;
          op_ori:  ctrl.alu_op = alu_or;
          op_xori: ctrl.alu_op = alu_xor;
          op_lui:  ctrl.alu_op = alu_lui;
          default: ctrl.alu_op = alu_add;
        endcase
      end
      op_lw, op_lb, op_lbu, op_lh, op_lhu: begin
        ctrl.alu_src_imm = 1'b1;  // address is rs plus the signed offset.
        ctrl.reg_write   = 1'b1;
        ctrl.wb_src      = wb_mem;
        ctrl.mem_read    = 1'b1;
        case (opcode)
          op_lb:   ctrl.load_kind = ld_byte_s;
          op_lbu:  ctrl.load_kind = ld_byte_u;
          op_lh:   ctrl.load_kind = ld_half_s;
          op_lhu:  ctrl.load_kind = ld_half_u;
          default: ctrl.load_kind = ld_word;
        endcase
      end
      op_sw: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      default: ctrl = ctrl_nop;
    endcase
  end

endmodule

/* mips_datapath.sv */
`timescale 1ns/100ps

module mips_datapath
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  clk_enable,
  input  ctrl_t ctrl,
  input  word_t instr,
  input  word_t data_readdata,
  output word_t instr_address,
  output word_t data_address,
  output word_t data_writedata,
  output logic  data_write,
  output logic  data_read,
  output word_t register_v0,
  output word_t register_v3,
  output logic  halted
);

  word_t      pc;
  word_t      pc_plus4;
  word_t      pc_plus8;
  logic       redirect_pending;
  word_t      redirect_target;
  word_t      next_target;
  logic       branch_taken;
  logic       take_redirect;
  logic       retire;
  reg_addr_t  dst_addr;
  word_t      rs_data;
  word_t      rt_data;
  word_t      imm_ext;
  word_t      alu_b;
  shamt_t     alu_shamt;
  word_t      alu_result;
  logic       alu_zero;
  logic [7:0] load_byte;
  logic [15:0] load_half;
  word_t      load_data;
  word_t      wb_data;

  assign halted        = (pc == '0);
  assign retire        = clk_enable & ~halted;  // one instruction per enabled edge.
  assign instr_address = pc;
  assign pc_plus4      = pc + 32'd4;
  assign pc_plus8      = pc + 32'd8;

  assign imm_ext   = ctrl.imm_zero_ext ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
  assign alu_b     = ctrl.alu_src_imm ? imm_ext : rt_data;
  assign alu_shamt = ctrl.shift_by_shamt ? instr[10:6] : rs_data[4:0];

  mips_regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .write_en (ctrl.reg_write & retire),
    .rs_addr  (instr[25:21]),
    .rt_addr  (instr[20:16]),
    .rd_addr  (dst_addr),
    .rd_data  (wb_data),
    .rs_data  (rs_data),
    .rt_data  (rt_data),
    .v0       (register_v0),
    .v3       (register_v3)
  );

  mips_alu u_alu (
    .op     (ctrl.alu_op),
    .a      (rs_data),
    .b      (alu_b),
    .shamt  (alu_shamt),
    .result (alu_result),
    .zero   (alu_zero)
  );

  assign branch_taken  = (ctrl.branch_eq & alu_zero) | (ctrl.branch_ne & ~alu_zero);
  assign take_redirect = branch_taken | ctrl.jump_imm | ctrl.jump_reg;

  always_comb begin
    if (ctrl.jump_reg) begin
      next_target = rs_data;
    end else if (ctrl.jump_imm) begin
      next_target = {pc_plus4[31:28], instr[25:0], 2'b00};  // stays in the delay slot's region.
    end else begin
      next_target = pc_plus4 + {imm_ext[29:0], 2'b00};
    end
  end

  // a redirect is held for one instruction so that the delay slot runs first.
  always_ff @(posedge clk) begin
    if (reset) begin
      pc               <= reset_vector;
      redirect_pending <= 1'b0;
    end else if (retire) begin
      pc               <= redirect_pending ? redirect_target : pc_plus4;
      redirect_pending <= take_redirect;
    end
  end

  always_ff @(posedge clk) begin
    if (retire && take_redirect) begin
      redirect_target <= next_target;
    end
  end

  assign data_address   = alu_result;
  assign data_writedata = rt_data;
  assign data_read      = ctrl.mem_read;
  assign data_write     = ctrl.mem_write & retire;  // no store during a stall or after halt.

  // little-endian lanes within the word; address bits 1:0 pick the lane.
  assign load_byte = data_readdata[8*data_address[1:0] +: 8];
  assign load_half = data_address[1] ? data_readdata[31:16] : data_readdata[15:0];

  always_comb begin
    case (ctrl.load_kind)
      ld_byte_s: load_data = {{24{load_byte[7]}}, load_byte};
      ld_byte_u: load_data = {24'b0, load_byte};
      ld_half_s: load_data = {{16{load_half[15]}}, load_half};
      ld_half_u: load_data = {16'b0, load_half};
      default:   load_data = data_readdata;
    endcase
  end

  always_comb begin
    case (ctrl.wb_src)
      wb_mem:  wb_data = load_data;
      wb_link: wb_data = pc_plus8;  // return point skips the delay slot.
      default: wb_data = alu_result;
    endcase
  end

  always_comb begin
    case (ctrl.dst_sel)
      dst_rd:  dst_addr = instr[15:11];
      dst_ra:  dst_addr = reg_ra;
      default: dst_addr = instr[20:16];
    endcase
  end

endmodule

/* mips_cpu_harvard.sv */
`timescale 1ns/100ps

module mips_cpu_harvard
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  output logic  active,
  output word_t register_v0,
  output word_t register_v3,
  input  logic  clk_enable,
  output word_t instr_address,
  input  word_t instr_readdata,
  output word_t data_address,
  output logic  data_write,
  output logic  data_read,
  output word_t data_writedata,
  input  word_t data_readdata
);

  ctrl_t ctrl;
  logic  halted;

  mips_controller u_controller (
    .instr (instr_readdata),
    .ctrl  (ctrl)
  );

  mips_datapath u_datapath (
    .clk            (clk),
    .reset          (reset),
    .clk_enable     (clk_enable),
    .ctrl           (ctrl),
    .instr          (instr_readdata),
    .data_readdata  (data_readdata),
    .instr_address  (instr_address),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .data_write     (data_write),
    .data_read      (data_read),
    .register_v0    (register_v0),
    .register_v3    (register_v3),
    .halted         (halted)
  );

  // the pc never leaves address 0, so once cleared active stays low.
  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b1;
    end else if (clk_enable && halted) begin
      active <= 1'b0;
    end
  end

endmodule

/* mips_cpu_assert.sv */
`timescale 1ns/100ps

module mips_cpu_assert
  import mips_isa_pkg::*;
(
  input logic  clk,
  input logic  reset,
  input logic  clk_enable,
  input logic  active,
  input logic  data_write,
  input logic  data_read,
  input word_t instr_address
);

  pc_at_reset_vector: assert property (@(posedge clk) reset |=> instr_address == reset_vector)
    else $error("instr_address is not the reset vector after reset");

  exclusive_mem_access: assert property (@(posedge clk) disable iff (reset)
    !(data_write && data_read))
    else $error("data_write and data_read are high together");

  // a halted CPU never wakes up and never stores.
  halt_is_final: assert property (@(posedge clk) disable iff (reset)
    !active |=> !active && !data_write)
    else $error("activity after the CPU halted");

  stall_holds_pc: assert property (@(posedge clk) disable iff (reset)
    !clk_enable |=> $stable(instr_address))
    else $error("instr_address moved during a stall");

endmodule

/* tb_mips_cpu_harvard.sv */
`timescale 1ns/100ps

module tb_mips_cpu_harvard
  import mips_isa_pkg::*;
();

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic        clk_enable = 1'b1;
  logic        active;
  logic        data_write;
  logic        data_read;
  word_t       register_v0;
  word_t       register_v3;
  word_t       instr_address;
  word_t       instr_readdata;
  word_t       data_address;
  word_t       data_writedata;
  word_t       data_readdata;
  word_t       rom [256];
  word_t       ram [256];
  word_t       ref_mem [256];
  word_t       ref_regs [32];
  word_t       ref_pc;
  word_t       ref_target;
  logic        ref_pending;
  logic        halt_seen = 1'b0;
  int          prog_len = 0;
  int          cycle_limit = 1000;
  int          cycles = 0;
  int          ref_stores = 0;
  int          dut_stores = 0;

  always #50 clk = ~clk;

  mips_cpu_harvard u_mips_cpu_harvard (
    .clk            (clk),
    .reset          (reset),
    .active         (active),
    .register_v0    (register_v0),
    .register_v3    (register_v3),
    .clk_enable     (clk_enable),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata)
  );

  bind mips_cpu_harvard mips_cpu_assert u_cpu_assert (
    .clk           (clk),
    .reset         (reset),
    .clk_enable    (clk_enable),
    .active        (active),
    .data_write    (data_write),
    .data_read     (data_read),
    .instr_address (instr_address)
  );

  function automatic word_t fetch(word_t addr);
    if (addr[31:10] == reset_vector[31:10]) begin
      return rom[addr[9:2]];
    end
    return '0;  // address 0 and everything outside the rom read as a nop.
  endfunction

  function automatic word_t fill_word(int i);
    return {~i[7:0], i[7:0] | 8'h80, i[7:0], i[7:0] ^ 8'h5A};  // two negative and two positive lanes.
  endfunction

  // the five load opcodes are the only instructions that read data memory.
  function automatic logic is_load(word_t ins);
    case (opcode_e'(ins[31:26]))
      op_lb, op_lh, op_lw, op_lbu, op_lhu: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  assign instr_readdata = fetch(instr_address);
  assign data_readdata  = ram[data_address[9:2]];

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 256; i++) begin
        ram[i] <= fill_word(i);
      end
    end else if (data_write) begin
      ram[data_address[9:2]] <= data_writedata;
      dut_stores <= dut_stores + 1;
    end
  end

  function automatic word_t enc_r(int rs, int rt, int rd, int sh, funct_e fn);
    return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
  endfunction

  function automatic word_t enc_i(opcode_e op, int rs, int rt, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic word_t enc_j(opcode_e op, int index);
    word_t target;
    target = reset_vector + 32'(4 * index);
    return {op, target[27:2]};
  endfunction

  task automatic emit(word_t ins);
    rom[prog_len] = ins;
    prog_len++;
  endtask

  task automatic emit_stores(int base);
    for (int r = 1; r <= 8; r++) begin
      emit(enc_i(op_sw, 0, (r == 8) ? 31 : r, base + 4 * r));  // the last one is ra.
    end
  endtask

  task automatic build_program();
    funct_e  r_ops [10] = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor,
                            fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra};
    opcode_e i_ops [6]  = '{op_addiu, op_andi, op_ori, op_xori, op_slti, op_lui};
    int      at;
    emit(enc_i(op_lui, 0, 1, 'h8000));
    emit(enc_i(op_ori, 1, 1, 'h1234));
    emit(enc_i(op_addiu, 0, 2, -5));
    emit(enc_r(1, 2, 3, 0, fn_slt));
    emit(enc_r(2, 1, 4, 0, fn_sltu));  // unsigned view of -5 is large.
    emit(enc_i(op_slti, 2, 5, 1));
    emit(enc_r(0, 1, 6, 4, fn_sra));
    emit(enc_r(0, 1, 7, 4, fn_srl));
    emit(enc_r(0, 2, 2, 3, fn_sll));
    emit(enc_r(1, 1, 0, 0, fn_addu));
    emit(enc_i(op_ori, 0, 0, 'h7777));
    emit_stores('h200);
    for (int k = 0; k < 4; k++) begin
      at = 'h80 + 8 * k;
      emit(enc_i(op_lb, 0, 1, at + k));
      emit(enc_i(op_lbu, 0, 2, at + k));
      emit(enc_i(op_lb, 0, 3, at + 4 + k));
      emit(enc_i(op_lbu, 0, 4, at + 4 + k));
      emit(enc_i(op_lh, 0, 5, at + (k & 2)));
      emit(enc_i(op_lhu, 0, 6, at + 4 + (k & 2)));
      emit(enc_i(op_lw, 0, 7, at));
      emit_stores('h240 + 'h40 * k);
    end
    for (int n = 0; n < 40; n++) begin
      if ($urandom_range(1) == 0) begin
        emit(enc_r($urandom_range(7, 1), $urandom_range(7, 1), $urandom_range(7, 1),
                   $urandom_range(31), r_ops[$urandom_range(9)]));
      end else begin
        emit(enc_i(i_ops[$urandom_range(5)], $urandom_range(7, 1), $urandom_range(7, 1),
                   $urandom_range('hFFFF)));
      end
    end
    emit_stores('h100);
    emit(enc_i(op_addiu, 0, 1, 5));
    emit(enc_i(op_addiu, 0, 2, 5));
    emit(enc_i(op_beq, 1, 2, 2));
    emit(enc_i(op_addiu, 0, 3, 1));  // delay slot runs although the branch is taken.
    emit(enc_i(op_addiu, 0, 3, 99));
    emit(enc_i(op_bne, 1, 2, 2));
    emit(enc_i(op_addiu, 3, 4, 2));
    emit(enc_i(op_addiu, 4, 4, 3));
    emit(enc_i(op_beq, 1, 0, 2));
    emit(enc_i(op_addiu, 4, 5, 1));
    emit(enc_i(op_addiu, 5, 5, 1));
    emit(enc_i(op_bne, 1, 0, 2));
    emit(enc_i(op_addiu, 5, 6, 1));
    emit(enc_i(op_addiu, 0, 6, 77));
    emit(enc_j(op_jal, prog_len + 3));
    emit(enc_i(op_addiu, 6, 7, 1));
    emit(enc_i(op_addiu, 0, 7, 55));
    emit(enc_j(op_j, prog_len + 3));
    emit(enc_i(op_ori, 0, 2, 'hAA));
    emit(enc_i(op_ori, 0, 2, 'hBB));
    emit_stores('h140);
    emit(enc_r(0, 0, 0, 0, fn_jr));
    emit(32'h0000_0000);
  endtask

  // one instruction of the instruction-set model, including the delay slot.
  function automatic void ref_step(output logic st, output word_t st_addr, output word_t st_data);
    word_t     ins;
    word_t     a;
    word_t     b;
    word_t     se;
    word_t     ze;
    word_t     ea;
    word_t     lane;
    word_t     pc4;
    word_t     val;
    word_t     jump_to;
    logic      wr;
    logic      jump;
    reg_addr_t dst;
    ins     = fetch(ref_pc);
    a       = ref_regs[ins[25:21]];
    b       = ref_regs[ins[20:16]];
    se      = {{16{ins[15]}}, ins[15:0]};
    ze      = {16'h0000, ins[15:0]};
    ea      = a + se;
    lane    = ref_mem[ea[9:2]] >> {ea[1:0], 3'b000};
    pc4     = ref_pc + 32'd4;
    st      = 1'b0;
    st_addr = '0;
    st_data = '0;
    val     = '0;
    wr      = 1'b1;
    jump    = 1'b0;
    jump_to = '0;
    dst     = ins[20:16];
    case (opcode_e'(ins[31:26]))
      op_special: begin
        dst = ins[15:11];
        case (funct_e'(ins[5:0]))
          fn_addu: val = a + b;
          fn_subu: val = a - b;
          fn_and:  val = a & b;
          fn_or:   val = a | b;
          fn_xor:  val = a ^ b;
          fn_slt:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          fn_sltu: val = (a < b) ? 32'd1 : 32'd0;
          fn_sll:  val = b << ins[10:6];
          fn_srl:  val = b >> ins[10:6];
          fn_sra:  val = $signed(b) >>> ins[10:6];
          fn_jr: begin
            wr      = 1'b0;
            jump    = 1'b1;
            jump_to = a;
          end
          default: wr = 1'b0;
        endcase
      end
      op_addiu: val = a + se;
      op_slti:  val = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
      op_andi:  val = a & ze;
      op_ori:   val = a | ze;
      op_xori:  val = a ^ ze;
      op_lui:   val = {ins[15:0], 16'h0000};
      op_lw:    val = ref_mem[ea[9:2]];
      op_lb:    val = {{24{lane[7]}}, lane[7:0]};
      op_lbu:   val = {24'h000000, lane[7:0]};
      op_lh:    val = {{16{lane[15]}}, lane[15:0]};
      op_lhu:   val = {16'h0000, lane[15:0]};
      op_sw: begin
        wr                = 1'b0;
        st                = 1'b1;
        st_addr           = ea;
        st_data           = b;
        ref_mem[ea[9:2]] = b;
      end
      op_beq, op_bne: begin
        wr      = 1'b0;
        jump    = (a == b) ^ ins[26];  // bit 26 tells bne from beq.
        jump_to = pc4 + (se << 2);
      end
      op_j, op_jal: begin
        wr      = ins[26];  // only jal links.
        dst     = reg_ra;
        val     = pc4 + 32'd4;
        jump    = 1'b1;
        jump_to = {pc4[31:28], ins[25:0], 2'b00};
      end
      default: wr = 1'b0;
    endcase
    if (wr && dst != 5'd0) begin
      ref_regs[dst] = val;
    end
    ref_pc      = ref_pending ? ref_target : pc4;
    ref_pending = jump;
    if (jump) begin
      ref_target = jump_to;
    end
  endfunction

  task automatic fail_run(string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
    end
  endtask

  // outputs are stable at the falling edge; the model steps for the next rising edge.
  always @(negedge clk) begin : compare
    logic  exp_store;
    word_t exp_addr;
    word_t exp_data;
    if (reset) begin
      for (int r = 0; r < 32; r++) begin
        ref_regs[r] = '0;
      end
      for (int i = 0; i < 256; i++) begin
        ref_mem[i] = fill_word(i);
      end
      ref_pc      = reset_vector;
      ref_target  = '0;
      ref_pending = 1'b0;
    end else begin
      check_word("instr_address", instr_address, ref_pc);
      check_word("register_v0", register_v0, ref_regs[reg_v0]);
      check_word("register_v3", register_v3, ref_regs[reg_v3]);
      check_bit("active", active, !halt_seen);
      check_bit("data_read", data_read, is_load(fetch(ref_pc)));
      if (clk_enable && instr_address != '0) begin
        ref_step(exp_store, exp_addr, exp_data);
        check_bit("data_write", data_write, exp_store);
        if (exp_store) begin
          check_word("data_address", data_address, exp_addr);
          check_word("data_writedata", data_writedata, exp_data);
          ref_stores++;
        end
      end else begin
        check_bit("data_write", data_write, 1'b0);  // stalled or halted.
        if (clk_enable) begin
          halt_seen = 1'b1;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (!reset) begin
      clk_enable <= ($urandom_range(3) != 0);  // about one cycle in four stalls.
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      fail_run("timeout: the CPU did not halt within the cycle limit");
    end
  end

  initial begin
    void'($urandom(6));
    build_program();
    cycle_limit = 4 * prog_len + prog_len + 3 + 6;  // stalls, reset and the cycles after the halt.
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    wait (halt_seen);
    repeat (6) @(posedge clk);
    if (dut_stores == ref_stores && ref_stores > 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      fail_run($sformatf("store count differs: DUT %0d, model %0d", dut_stores, ref_stores));
    end
  end

endmodule

/* flist.f */
mips_isa_pkg.sv
mips_ctrl_pkg.sv
mips_alu.sv
mips_regfile.sv
mips_controller.sv
mips_datapath.sv
mips_cpu_harvard.sv
mips_cpu_assert.sv
tb_mips_cpu_harvard.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_mips_cpu_harvard -f flist.f -o sim_mips
output=$(./obj_dir/sim_mips 2>&1) || true
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qF '*** PASSED ***'
